// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // the cache has eight lines of two instructions
  localparam int offset_bits = 3;
  localparam int index_bits  = 3;
  localparam int tag_bits    = 32 - index_bits - offset_bits;
  localparam int line_words  = 2;  // also the beats per read burst

  localparam logic [31:0] reset_pc        = 32'h3000_0000;
  localparam logic [7:0]  uncached_region = 8'h0f;  // top address byte that skips the cache

  // the fetch address is used both as a plain word and split for the cache lookup
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [tag_bits-1:0]    tag;
      logic [index_bits-1:0]  index;
      logic [offset_bits-1:0] offset;  // top bit picks the word in the line
    } part;
  } fetch_addr_u;

  typedef struct packed {
    logic [31:0] word1;  // instruction at offset 4
    logic [31:0] word0;  // instruction at offset 0
  } cache_line_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetched_inst_t;

  // one beat of the read data channel
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
  } read_beat_t;

endpackage

`default_nettype wire

// ==== fetch_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear_pipeline,
  input  logic                  npc_valid,
  input  logic                  advance,
  input  logic [31:0]           npc,
  input  logic [31:0]           snpc,
  output fetch_pkg::fetch_addr_u pc,
  output logic                  may_miss
);

  fetch_pkg::fetch_addr_u pc_q;
  logic                   pipeline_empty;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q.raw       <= fetch_pkg::reset_pc;
      pipeline_empty <= 1'b1;
    end else if (clear_pipeline) begin
      pc_q.raw       <= npc;  // redirect wins over a delivery in the same cycle
      pipeline_empty <= 1'b1;
    end else if (advance) begin
      pc_q.raw       <= pc_q.raw + 32'd4;
      pipeline_empty <= 1'b0;
    end
  end

  assign pc = pc_q;

  // with instructions in flight the pc might be on a wrong path, so memory is only
  // touched once decode has confirmed that the sequential pc is the real next pc
  assign may_miss = pipeline_empty || (npc_valid && (snpc == pc_q.raw));

endmodule

`default_nettype wire

// ==== icache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_array (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   clear_cache,
  input  fetch_pkg::fetch_addr_u pc,
  input  logic                   fill,
  input  fetch_pkg::cache_line_t fill_line,
  output logic                   hit,
  output fetch_pkg::cache_line_t line
);

  logic [2**fetch_pkg::index_bits-1:0] valid;
  logic [fetch_pkg::tag_bits-1:0]      tags  [2**fetch_pkg::index_bits];
  fetch_pkg::cache_line_t              lines [2**fetch_pkg::index_bits];

  logic [fetch_pkg::index_bits-1:0] index;
  assign index = pc.part.index;

  // reset and a flush drop every line at once
  always_ff @(posedge clock) begin
    if (reset || clear_cache) begin
      valid <= '0;
    end else if (fill) begin
      valid[index] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (fill) begin
      tags[index]  <= pc.part.tag;
      lines[index] <= fill_line;
    end
  end

  // direct mapped, so a single compare decides the hit
  assign hit  = valid[index] && (tags[index] == pc.part.tag);
  assign line = lines[index];

endmodule

`default_nettype wire

// ==== fetch_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
  input  logic                     clock,
  input  logic                     reset,
  input  fetch_pkg::fetch_addr_u   pc,
  input  logic                     may_miss,
  input  logic                     hit,
  input  logic                     idu_ready,
  input  logic                     block,
  input  logic                     clear_pipeline,
  input  fetch_pkg::cache_line_t   line,
  input  logic                     done,
  input  fetch_pkg::cache_line_t   burst_line,
  output logic                     start,
  output logic                     fill,
  output logic                     advance,
  output logic                     busy,
  output logic                     inst_valid,
  output fetch_pkg::fetched_inst_t inst_out
);

  logic                   reading;     // low means idle and reading the cache
  logic                   redirected;  // a redirect came in while the burst was running
  fetch_pkg::fetch_addr_u burst_pc;

  logic cacheable;
  logic burst_cacheable;
  logic same_line;
  logic can_fetch;
  logic deliver_hit;
  logic deliver_mem;
  logic word_sel;

  assign cacheable       = pc.raw[31:24] != fetch_pkg::uncached_region;
  assign burst_cacheable = burst_pc.raw[31:24] != fetch_pkg::uncached_region;
  assign same_line       = (pc.part.tag == burst_pc.part.tag) &&
                           (pc.part.index == burst_pc.part.index);
  assign word_sel        = pc.part.offset[fetch_pkg::offset_bits-1];

  assign can_fetch   = !reading && idu_ready && !block && !clear_pipeline;
  assign deliver_hit = can_fetch && cacheable && hit;
  assign start       = can_fetch && (!cacheable || (!hit && may_miss));
  assign deliver_mem = reading && done && !redirected && !clear_pipeline;

  assign advance = deliver_hit || deliver_mem;
  assign busy    = reading;

  // the array writes at the current pc, so after a redirect the line is only
  // kept when the new pc still falls inside it
  assign fill = reading && done && burst_cacheable && same_line;

  always_ff @(posedge clock) begin
    if (reset) begin
      reading    <= 1'b0;
      redirected <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= advance;
      if (start) begin
        reading    <= 1'b1;
        redirected <= 1'b0;
      end else if (reading) begin
        if (done) reading <= 1'b0;
        if (clear_pipeline) redirected <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) burst_pc <= pc;
    if (advance) begin
      inst_out.pc   <= pc.raw;
      inst_out.inst <= reading ? (word_sel ? burst_line.word1 : burst_line.word0)
                               : (word_sel ? line.word1 : line.word0);
    end
  end

endmodule

`default_nettype wire

// ==== burst_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_reader (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start,
  input  fetch_pkg::fetch_addr_u pc,
  output logic [31:0]            araddr,
  output logic                   arvalid,
  input  logic                   arready,
  input  logic                   rvalid,
  output logic                   rready,
  input  fetch_pkg::read_beat_t  rbeat,
  output logic                   done,
  output fetch_pkg::cache_line_t line
);

  logic        beat_count;
  logic [31:0] word0;
  logic        beat_taken;
  logic        last_beat;

  assign beat_taken = rready && rvalid;
  // the response code is ignored and every burst is taken as good
  assign last_beat  = rbeat.last || (beat_count == 1'(fetch_pkg::line_words - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      arvalid    <= 1'b0;
      rready     <= 1'b0;
      beat_count <= 1'b0;
    end else begin
      if (start) begin
        arvalid    <= 1'b1;
        beat_count <= 1'b0;
      end else if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;  // address accepted, now wait for the data beats
      end
      if (beat_taken) begin
        if (last_beat) rready <= 1'b0;
        beat_count <= beat_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      araddr <= {pc.part.tag, pc.part.index, {fetch_pkg::offset_bits{1'b0}}};
    end
    if (beat_taken && !last_beat) word0 <= rbeat.data;
  end

  // the last beat goes straight into the line so the instruction is out a cycle later
  assign done       = beat_taken && last_beat;
  assign line.word1 = rbeat.data;
  assign line.word0 = word0;

endmodule

`default_nettype wire

// ==== fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     npc_valid,
  input  logic [31:0]              npc,
  input  logic [31:0]              snpc,
  input  logic                     idu_ready,
  input  logic                     block,
  input  logic                     clear_cache,
  input  logic                     clear_pipeline,
  output logic                     inst_valid,
  output fetch_pkg::fetched_inst_t inst_out,
  output logic                     enable,
  output logic [31:0]              araddr,
  output logic                     arvalid,
  input  logic                     arready,
  input  logic                     rvalid,
  output logic                     rready,
  input  fetch_pkg::read_beat_t    rbeat
);

  fetch_pkg::fetch_addr_u pc;
  fetch_pkg::cache_line_t hit_line;
  fetch_pkg::cache_line_t burst_line;
  logic                   may_miss;
  logic                   hit;
  logic                   advance;
  logic                   fill;
  logic                   start;
  logic                   done;

  fetch_pc pc0 (
    .clock          (clock),
    .reset          (reset),
    .clear_pipeline (clear_pipeline),
    .npc_valid      (npc_valid),
    .advance        (advance),
    .npc            (npc),
    .snpc           (snpc),
    .pc             (pc),
    .may_miss       (may_miss)
  );

  icache_array cache0 (
    .clock       (clock),
    .reset       (reset),
    .clear_cache (clear_cache),
    .pc          (pc),
    .fill        (fill),
    .fill_line   (burst_line),
    .hit         (hit),
    .line        (hit_line)
  );

  fetch_control ctrl0 (
    .clock          (clock),
    .reset          (reset),
    .pc             (pc),
    .may_miss       (may_miss),
    .hit            (hit),
    .idu_ready      (idu_ready),
    .block          (block),
    .clear_pipeline (clear_pipeline),
    .line           (hit_line),
    .done           (done),
    .burst_line     (burst_line),
    .start          (start),
    .fill           (fill),
    .advance        (advance),
    .busy           (enable),
    .inst_valid     (inst_valid),
    .inst_out       (inst_out)
  );

  burst_reader reader0 (
    .clock   (clock),
    .reset   (reset),
    .start   (start),
    .pc      (pc),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rbeat   (rbeat),
    .done    (done),
    .line    (burst_line)
  );

endmodule

`default_nettype wire

// ==== tb_fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_unit;

  localparam int num_tests = 6;

  logic clock, reset, idu_ready, block, clear_cache, clear_pipeline;
  logic npc_valid, arready, rvalid;
  logic [31:0] npc, snpc;
  fetch_pkg::read_beat_t rbeat;
  logic inst_valid, enable, arvalid, rready;
  logic [31:0] araddr;
  fetch_pkg::fetched_inst_t inst_out;

  fetch_pkg::fetched_inst_t got_q[$];
  logic [31:0] mem [logic [31:0]];
  logic [31:0] burst_addr, word_addr;
  logic data_phase, beat, hold_mem, confirm;
  int stall, bursts, base;

  fetch_unit dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  initial begin
    repeat (num_tests * 200 + 200) @(posedge clock);
    report_failure("watchdog expired before all tests finished");
  end

  // memory content follows from the whole address
  function automatic logic [31:0] pattern(logic [31:0] addr);
    return {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
  endfunction

  function automatic fetch_pkg::fetched_inst_t expected(logic [31:0] pc);
    fetch_pkg::fetched_inst_t e;
    e.pc   = pc;
    e.inst = pattern(pc);
    return e;
  endfunction

  // burst memory that stalls both channels at random
  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rbeat   = '0;
    forever begin
      @(posedge clock);
      if (reset) begin
        arready    <= 1'b0;
        rvalid     <= 1'b0;
        data_phase <= 1'b0;
        beat       <= 1'b0;
        stall      <= 0;
        bursts     <= 0;
      end else if (!data_phase) begin
        if (arvalid && arready) begin
          arready    <= 1'b0;
          burst_addr <= araddr;
          bursts     <= bursts + 1;
          data_phase <= 1'b1;
          stall      <= $urandom_range(3, 0);
        end else if (arvalid && !hold_mem) begin
          if (stall == 0) arready <= 1'b1;
          else stall <= stall - 1;
        end
      end else if (rvalid && rready) begin
        rvalid     <= 1'b0;
        beat       <= !beat;
        data_phase <= !beat;  // the second beat ends the burst
        stall      <= $urandom_range(3, 0);
      end else if (!rvalid && !hold_mem) begin
        if (stall == 0) begin
          word_addr = burst_addr + (beat ? 32'd4 : 32'd0);
          if (!mem.exists(word_addr)) mem[word_addr] = pattern(word_addr);
          rvalid     <= 1'b1;
          rbeat.data <= mem[word_addr];
          rbeat.resp <= 2'b00;
          rbeat.last <= beat;
        end else stall <= stall - 1;
      end
    end
  end

  // decode confirms the sequential successor only while confirm is set
  initial begin
    npc_valid = 1'b0;
    snpc      = '0;
    forever begin
      @(posedge clock);
      npc_valid <= confirm;
      if (inst_valid) snpc <= inst_out.pc + 32'd4;
    end
  end

  always @(posedge clock) begin
    if (!reset && inst_valid) got_q.push_back(inst_out);
  end

  task automatic report_failure(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_inst(fetch_pkg::fetched_inst_t got, fetch_pkg::fetched_inst_t exp);
    if (got !== exp)
      report_failure($sformatf("MISMATCH at %0t: got pc %h inst %h, expected pc %h inst %h",
                               $time, got.pc, got.inst, exp.pc, exp.inst));
  endtask

  task automatic check_count(int got, int exp, string what);
    if (got != exp)
      report_failure($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  task automatic check_addr(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp)
      report_failure($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_level(logic got, logic exp, string what);
    if (got !== exp)
      report_failure($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  task automatic expect_fetch(logic [31:0] pc);
    int waited;
    waited = 0;
    while (got_q.size() == 0) begin
      if (waited == 100) report_failure($sformatf("no instruction for pc %h arrived", pc));
      else begin
        @(negedge clock);
        waited++;
      end
    end
    check_inst(got_q.pop_front(), expected(pc));
  endtask

  task automatic wait_for_read();
    int waited;
    waited = 0;
    while (!arvalid) begin
      if (waited == 100) report_failure("no read address was issued");
      else begin
        @(negedge clock);
        waited++;
      end
    end
  endtask

  // anything delivered before the redirect took effect is dropped from the queue
  task automatic redirect(logic [31:0] target);
    @(posedge clock);
    clear_pipeline <= 1'b1;
    npc            <= target;
    @(posedge clock);
    clear_pipeline <= 1'b0;
    @(negedge clock);
    got_q.delete();
  endtask

  task automatic first_fetch();
    expect_fetch(fetch_pkg::reset_pc);
    check_count(bursts, 1, "bursts after reset");
    check_addr(burst_addr, fetch_pkg::reset_pc, "first burst address");
  endtask

  task automatic same_line_refetch();
    base = bursts;
    expect_fetch(fetch_pkg::reset_pc + 32'd4);
    redirect(fetch_pkg::reset_pc);
    expect_fetch(fetch_pkg::reset_pc);
    expect_fetch(fetch_pkg::reset_pc + 32'd4);
    repeat (5) @(negedge clock);
    check_count(bursts - base, 0, "bursts for a cached line");
  endtask

  task automatic uncached_fetches();
    base = bursts;
    redirect(32'h0f00_0000);
    expect_fetch(32'h0f00_0000);
    check_count(bursts - base, 1, "uncached bursts");
    expect_fetch(32'h0f00_0004);
    check_count(bursts - base, 2, "uncached bursts");
    hold_mem = 1'b1;  // third burst waits at the address phase
    redirect(32'h0f00_0000);
    hold_mem = 1'b0;
    expect_fetch(32'h0f00_0000);
    check_count(bursts - base, 4, "uncached bursts after a repeated address");
    redirect(fetch_pkg::reset_pc);
    expect_fetch(fetch_pkg::reset_pc);
    expect_fetch(fetch_pkg::reset_pc + 32'd4);
  endtask

  task automatic redirect_fetches();
    base = bursts;
    redirect(32'h3000_0020);
    expect_fetch(32'h3000_0020);
    expect_fetch(32'h3000_0024);
    hold_mem = 1'b1;
    redirect(32'h3000_0030);
    wait_for_read();
    check_level(enable, 1'b1, "enable during a stalled burst");
    check_addr(araddr, 32'h3000_0030, "address of the stalled burst");
    redirect(32'h3000_0010);
    hold_mem = 1'b0;
    expect_fetch(32'h3000_0010);
    expect_fetch(32'h3000_0014);
    check_count(bursts - base, 3, "bursts around a redirect");
  endtask

  task automatic flush_refetch();
    base = bursts;
    redirect(fetch_pkg::reset_pc);
    expect_fetch(fetch_pkg::reset_pc);
    expect_fetch(fetch_pkg::reset_pc + 32'd4);
    check_count(bursts - base, 0, "bursts before the flush");
    @(posedge clock);
    clear_cache <= 1'b1;
    @(posedge clock);
    clear_cache <= 1'b0;
    redirect(fetch_pkg::reset_pc);
    expect_fetch(fetch_pkg::reset_pc);
    expect_fetch(fetch_pkg::reset_pc + 32'd4);
    check_count(bursts - base, 1, "bursts after the flush");
  endtask

  task automatic miss_guard();
    base = bursts;
    repeat (20) @(negedge clock);
    check_count(bursts - base, 0, "bursts while the pc is unconfirmed");
    check_count(got_q.size(), 0, "instructions while the pc is unconfirmed");
    check_level(enable, 1'b0, "enable while the pc is unconfirmed");
    confirm = 1'b1;
    expect_fetch(fetch_pkg::reset_pc + 32'd8);
    expect_fetch(fetch_pkg::reset_pc + 32'd12);
    check_count(bursts - base, 1, "bursts after decode confirms the pc");
    confirm = 1'b0;
  endtask

  initial begin
    void'($urandom(32'hda6e_8952));
    reset          = 1'b1;
    idu_ready      = 1'b1;
    block          = 1'b0;
    clear_cache    = 1'b0;
    clear_pipeline = 1'b0;
    npc            = '0;
    hold_mem       = 1'b0;
    confirm        = 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    first_fetch();
    same_line_refetch();
    uncached_fetches();
    redirect_fetches();
    flush_refetch();
    miss_guard();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
fetch_pkg.sv
fetch_pc.sv
icache_array.sv
fetch_control.sv
burst_reader.sv
fetch_unit.sv
tb_fetch_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f fetch_unit.f --top-module tb_fetch_unit -o sim_fetch_unit

# the simulator status is not trusted, the log decides
./obj_dir/sim_fetch_unit | tee sim.log

grep -q "Regression passed" sim.log
